/* command_issue_defs.svh */
/*
  constants shared by the command-issue path: tag pool, field widths,
  request queue depth and the host credits held after reset
  include wherever a width or a depth is needed
*/
`ifndef COMMAND_ISSUE_DEFS_SVH
`define COMMAND_ISSUE_DEFS_SVH

// host tag field width, tags 0..15 live in it
`define CMD_TAG_BITS 8
`define CMD_NUM_TAGS 16

// command word fields
`define CMD_CODE_BITS 13
`define CMD_ADDR_BITS 64
`define CMD_SIZE_BITS 12

// credit count, wide enough for any host return
`define CMD_CREDIT_BITS 8

// request queue entries, power of two
`define CMD_QUEUE_DEPTH 8

// credits granted by the host out of reset
`define CMD_INIT_CREDITS 4

`endif

/* command_issue_pkg.sv */
/*
  types shared across the command-issue path: command codes, abort modes,
  the request, command and response words, and the issue FSM states
  modules refer to these by scoped name
*/
`include "command_issue_defs.svh"

package command_issue_pkg;

  ////////////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////////////

  // host command codes, zero is never sent
  typedef enum logic [`CMD_CODE_BITS-1:0] {
    cmd_invalid    = 13'h0000,
    cmd_read_cl_na = 13'h0A00,
    cmd_write_na   = 13'h0D00,
    cmd_touch_i    = 13'h0240
  } cmd_code_t;

  // translation ordering, this path only drives strict
  typedef enum logic [2:0] {
    abt_strict = 3'b000,
    abt_abort  = 3'b001,
    abt_page   = 3'b010,
    abt_pref   = 3'b011,
    abt_spec   = 3'b100
  } abort_mode_t;

  ////////////////////////////////////////////////////////////////////
  // words
  ////////////////////////////////////////////////////////////////////

  // one pending request from the engine
  typedef struct packed {
    logic                      valid;
    cmd_code_t                 command;
    logic [`CMD_ADDR_BITS-1:0] address;
    logic [`CMD_SIZE_BITS-1:0] size;
  } cmd_request_t;

  // command as presented to the host
  typedef struct packed {
    logic                      valid;
    cmd_code_t                 command;
    logic                      command_parity;
    logic [`CMD_ADDR_BITS-1:0] address;
    logic                      address_parity;
    logic [`CMD_TAG_BITS-1:0]  tag;
    logic                      tag_parity;
    logic [`CMD_SIZE_BITS-1:0] size;
    abort_mode_t               abt;
    logic [15:0]               context_handle;
  } cmd_out_t;

  // host response, tag and credit return
  typedef struct packed {
    logic                        valid;
    logic [`CMD_TAG_BITS-1:0]    tag;
    logic                        tag_parity;
    logic [7:0]                  code;
    logic [`CMD_CREDIT_BITS-1:0] credits;
  } response_t;

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_drain
  } issue_state_t;

endpackage

/* request_queue.sv */
/*
  in-order queue of pending command requests
  head entry is always visible, pop takes it on the same edge as the issue
  a push while full is dropped
*/
`include "command_issue_defs.svh"

module request_queue (
  input  logic                            clock,
  input  logic                            rstn,
  input  logic                            push,
  input  command_issue_pkg::cmd_request_t req_in,
  input  logic                            pop,
  output command_issue_pkg::cmd_request_t head_req,
  output logic                            full,
  output logic                            empty
);

  localparam int unsigned PTR_BITS = $clog2(`CMD_QUEUE_DEPTH);

  logic [PTR_BITS-1:0] rd_ptr;
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS:0]   count;
  logic                do_push;
  logic                do_pop;

  command_issue_pkg::cmd_request_t entries [`CMD_QUEUE_DEPTH];

  // levels from occupancy
  assign full    = (count == (PTR_BITS + 1)'(`CMD_QUEUE_DEPTH));
  assign empty   = (count == '0);
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage
  always_ff @(posedge clock) begin
    if (do_push) begin
      entries[wr_ptr] <= req_in;
    end
  end

  // head view, valid only while something is queued
  always_comb begin
    head_req       = entries[rd_ptr];
    head_req.valid = ~empty;
  end

endmodule

/* tag_pool.sv */
/*
  free list of host command tags, filled with 0..15 in order out of reset
  take removes the head, a response with good odd tag parity appends its tag
  bad parity loses the tag and sets a sticky error
*/
`include "command_issue_defs.svh"

module tag_pool (
  input  logic                         clock,
  input  logic                         rstn,
  input  logic                         take,
  input  command_issue_pkg::response_t resp,
  output logic [`CMD_TAG_BITS-1:0]     free_tag,
  output logic                         tag_avail,
  output logic                         all_free,
  output logic                         parity_error
);

  localparam int unsigned IDX_BITS = $clog2(`CMD_NUM_TAGS);

  logic [`CMD_TAG_BITS-1:0] entries [`CMD_NUM_TAGS];
  logic [IDX_BITS-1:0]      head;
  logic [IDX_BITS-1:0]      tail;
  logic [IDX_BITS:0]        count;
  logic                     parity_ok;
  logic                     do_take;
  logic                     do_return;

  // odd parity, tag plus parity bit holds an odd count of ones
  assign parity_ok = ^{resp.tag, resp.tag_parity};

  assign tag_avail = (count != '0);
  assign all_free  = (count == (IDX_BITS + 1)'(`CMD_NUM_TAGS));
  assign free_tag  = entries[head];
  assign do_take   = take & tag_avail;
  // a stray return into a full pool is ignored
  assign do_return = resp.valid & parity_ok & (~all_free | do_take);

  ////////////////////////////////////////////////////////////////////
  // free list
  ////////////////////////////////////////////////////////////////////

  // the list itself is the reset state of the pool
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < `CMD_NUM_TAGS; i++) begin
        entries[i] <= `CMD_TAG_BITS'(i);
      end
      head  <= '0;
      tail  <= '0;
      count <= (IDX_BITS + 1)'(`CMD_NUM_TAGS);
    end else begin
      if (do_take) begin
        head <= head + 1'b1;
      end
      if (do_return) begin
        entries[tail] <= resp.tag;
        tail          <= tail + 1'b1;
      end
      case ({do_return, do_take})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // sticky until reset
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      parity_error <= 1'b0;
    end else if (resp.valid && !parity_ok) begin
      parity_error <= 1'b1;
    end
  end

endmodule

/* credit_counter.sv */
/*
  host command credit count
  one credit spent per issued command, response credits added back
  both may land on the same edge
*/
`include "command_issue_defs.svh"

module credit_counter (
  input  logic                         clock,
  input  logic                         rstn,
  input  logic                         consume,
  input  command_issue_pkg::response_t resp,
  output logic                         credit_avail
);

  logic [`CMD_CREDIT_BITS-1:0] credits;
  logic [`CMD_CREDIT_BITS-1:0] returned;
  logic [`CMD_CREDIT_BITS-1:0] spent;

  // credits only count on a valid response
  assign returned = resp.valid ? resp.credits : '0;

  // never spend below zero
  assign spent        = {{(`CMD_CREDIT_BITS - 1){1'b0}}, consume & credit_avail};
  assign credit_avail = (credits != '0);

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      credits <= `CMD_CREDIT_BITS'(`CMD_INIT_CREDITS);
    end else begin
      credits <= credits + returned - spent;
    end
  end

endmodule

/* issue_fsm.sv */
/*
  issue control FSM
  registers the enable, then runs, drains outstanding tags, or sits idle
  issue is combinational from registered state and the resource levels
*/
module issue_fsm (
  input  logic                            clock,
  input  logic                            rstn,
  input  logic                            enabled_in,
  input  logic                            queue_empty,
  input  logic                            credit_avail,
  input  logic                            tag_avail,
  input  logic                            all_free,
  output logic                            issue,
  output logic                            idle,
  output command_issue_pkg::issue_state_t state
);

  logic                            enabled;
  command_issue_pkg::issue_state_t state_next;

  ////////////////////////////////////////////////////////////////////
  // enable
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled <= 1'b0;
    end else begin
      enabled <= enabled_in;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // state
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    unique case (state)
      command_issue_pkg::st_idle: begin
        if (enabled) begin
          state_next = command_issue_pkg::st_run;
        end
      end
      command_issue_pkg::st_run: begin
        if (!enabled) begin
          state_next = command_issue_pkg::st_drain;
        end
      end
      command_issue_pkg::st_drain: begin
        // wait for every tag to come home
        if (all_free) begin
          state_next = command_issue_pkg::st_idle;
        end
      end
      default: state_next = command_issue_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      state <= command_issue_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

  // enable gates issue too, so issuing stops one cycle after it drops
  assign issue = (state == command_issue_pkg::st_run) & enabled & ~queue_empty &
                 credit_avail & tag_avail;
  assign idle  = (state == command_issue_pkg::st_idle);

endmodule

/* command_control.sv */
/*
  builds the host command word
  latch stage captures request and tag on issue, parity is taken from it,
  output stage registers the full word with strict abort and zero context
*/
`include "command_issue_defs.svh"

module command_control (
  input  logic                            clock,
  input  logic                            rstn,
  input  logic                            issue,
  input  command_issue_pkg::cmd_request_t command_in,
  input  logic [`CMD_TAG_BITS-1:0]        command_tag_in,
  output command_issue_pkg::cmd_out_t     command_out
);

  logic                          lat_valid;
  command_issue_pkg::cmd_code_t  lat_command;
  logic [`CMD_ADDR_BITS-1:0]     lat_address;
  logic [`CMD_SIZE_BITS-1:0]     lat_size;
  logic [`CMD_TAG_BITS-1:0]      lat_tag;
  logic                          out_valid;
  command_issue_pkg::cmd_out_t   out_word;

  ////////////////////////////////////////////////////////////////////
  // latch stage
  ////////////////////////////////////////////////////////////////////

  // valid is one cycle wide per issue
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      lat_valid <= 1'b0;
    end else begin
      lat_valid <= issue & command_in.valid;
    end
  end

  // payload holds between issues
  always_ff @(posedge clock) begin
    if (issue) begin
      lat_command <= command_in.command;
      lat_address <= command_in.address;
      lat_size    <= command_in.size;
      lat_tag     <= command_tag_in;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // output stage
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= lat_valid;
    end
  end

  // odd parity per field, inverted xor reduction
  always_ff @(posedge clock) begin
    out_word.valid          <= lat_valid;
    out_word.command        <= lat_command;
    out_word.command_parity <= ~^lat_command;
    out_word.address        <= lat_address;
    out_word.address_parity <= ~^lat_address;
    out_word.tag            <= lat_tag;
    out_word.tag_parity     <= ~^lat_tag;
    out_word.size           <= lat_size;
    out_word.abt            <= command_issue_pkg::abt_strict;
    // dedicated mode, context handle always zero
    out_word.context_handle <= 16'h0000;
  end

  always_comb begin
    command_out       = out_word;
    command_out.valid = out_valid;
  end

endmodule

/* command_issue_top.sv */
/*
  command-issue path top level
  request queue, tag pool and credit counter feed the issue FSM,
  command control turns each issue into a host command word
*/
`include "command_issue_defs.svh"

module command_issue_top (
  input  logic                            clock,
  input  logic                            rstn,
  input  logic                            enabled_in,
  input  command_issue_pkg::cmd_request_t req,
  input  command_issue_pkg::response_t    resp,
  output logic                            req_full,
  output command_issue_pkg::cmd_out_t     command_out,
  output logic                            idle,
  output logic                            parity_error
);

  command_issue_pkg::cmd_request_t head_req;
  command_issue_pkg::issue_state_t state;
  logic [`CMD_TAG_BITS-1:0]        free_tag;
  logic                            queue_empty;
  logic                            tag_avail;
  logic                            all_free;
  logic                            credit_avail;
  logic                            issue;

  ////////////////////////////////////////////////////////////////////
  // resources
  ////////////////////////////////////////////////////////////////////

  request_queue u_request_queue (
    .clock    (clock),
    .rstn     (rstn),
    .push     (req.valid),
    .req_in   (req),
    .pop      (issue),
    .head_req (head_req),
    .full     (req_full),
    .empty    (queue_empty)
  );

  tag_pool u_tag_pool (
    .clock        (clock),
    .rstn         (rstn),
    .take         (issue),
    .resp         (resp),
    .free_tag     (free_tag),
    .tag_avail    (tag_avail),
    .all_free     (all_free),
    .parity_error (parity_error)
  );

  credit_counter u_credit_counter (
    .clock        (clock),
    .rstn         (rstn),
    .consume      (issue),
    .resp         (resp),
    .credit_avail (credit_avail)
  );

  ////////////////////////////////////////////////////////////////////
  // issue and command build
  ////////////////////////////////////////////////////////////////////

  issue_fsm u_issue_fsm (
    .clock        (clock),
    .rstn         (rstn),
    .enabled_in   (enabled_in),
    .queue_empty  (queue_empty),
    .credit_avail (credit_avail),
    .tag_avail    (tag_avail),
    .all_free     (all_free),
    .issue        (issue),
    .idle         (idle),
    .state        (state)
  );

  command_control u_command_control (
    .clock          (clock),
    .rstn           (rstn),
    .issue          (issue),
    .command_in     (head_req),
    .command_tag_in (free_tag),
    .command_out    (command_out)
  );

endmodule

/* command_issue_asserts.sv */
/*
  protocol rules of the command-issue top level
  bound onto command_issue_top from the testbench
*/
module command_issue_asserts (
  input logic                            clock,
  input logic                            rstn,
  input command_issue_pkg::cmd_request_t req,
  input logic                            req_full,
  input command_issue_pkg::cmd_out_t     command_out,
  input logic                            idle,
  input logic                            issue,
  input command_issue_pkg::issue_state_t state
);
  timeunit 1ns;
  timeprecision 100ps;

  // requester must honour back-pressure
  no_push_when_full: assert property (@(posedge clock) disable iff (!rstn)
    req_full |-> !req.valid)
    else $error("request strobed while the queue is full");

  // nothing leaves while the path is idle
  no_command_when_idle: assert property (@(posedge clock) disable iff (!rstn)
    command_out.valid |-> !idle)
    else $error("command issued while idle");

  issue_only_in_run: assert property (@(posedge clock) disable iff (!rstn)
    issue |-> (state == command_issue_pkg::st_run))
    else $error("issue outside the run state");

  // each field with its parity bit holds an odd count of ones
  odd_parity_out: assert property (@(posedge clock) disable iff (!rstn)
    command_out.valid |-> (^{command_out.tag, command_out.tag_parity}) &&
                          (^{command_out.command, command_out.command_parity}) &&
                          (^{command_out.address, command_out.address_parity}))
    else $error("even parity on a command word");

endmodule

/* command_issue_tb.sv */
/*
  directed testbench for the command-issue path
  plays the requester and the host: strobes requests, returns tags and credits,
  and checks each command word against a model of the request queue and tag list
*/
`include "command_issue_defs.svh"

module command_issue_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 4;
  localparam logic [7:0] RESP_DONE = 8'h01;
  // rough cycle budget per test including reset
  localparam int LEN_TOTAL = 20 + 30 + 70 + 120 + 90 + 110;
  localparam int WATCHDOG_NS = LEN_TOTAL * 3 * CLK_PERIOD / 2;

  logic clock = 1'b0;
  logic rstn;
  logic enabled_in;
  logic req_full;
  logic idle;
  logic parity_error;
  command_issue_pkg::cmd_request_t req;
  command_issue_pkg::response_t    resp;
  command_issue_pkg::cmd_out_t     command_out;

  integer seed;
  int mismatch_count;
  int failure_count;
  int seen_count;
  // model of the DUT's pending requests, free list and outstanding tags
  command_issue_pkg::cmd_request_t exp_reqs[$];
  logic [`CMD_TAG_BITS-1:0] free_tags[$];
  logic [`CMD_TAG_BITS-1:0] out_tags[$];
  logic [`CMD_TAG_BITS-1:0] seen_tags[$];

  command_issue_top dut (
    .clock        (clock),
    .rstn         (rstn),
    .enabled_in   (enabled_in),
    .req          (req),
    .resp         (resp),
    .req_full     (req_full),
    .command_out  (command_out),
    .idle         (idle),
    .parity_error (parity_error)
  );

  bind command_issue_top command_issue_asserts u_asserts (
    .clock       (clock),
    .rstn        (rstn),
    .req         (req),
    .req_full    (req_full),
    .command_out (command_out),
    .idle        (idle),
    .issue       (issue),
    .state       (state)
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  //////////////////////////////////////////////////////////////////////
  // reference rules and checks
  //////////////////////////////////////////////////////////////////////

  // bit that makes the field plus itself hold an odd count of ones
  function automatic logic odd_parity(input logic [63:0] value, input int width);
    int ones;
    ones = 0;
    for (int i = 0; i < width; i++) begin
      if (value[i]) begin
        ones++;
      end
    end
    return (ones % 2) == 0;
  endfunction

  function automatic command_issue_pkg::cmd_out_t expected_cmd(
    input command_issue_pkg::cmd_request_t r, input logic [`CMD_TAG_BITS-1:0] tag);
    command_issue_pkg::cmd_out_t c;
    c = '0;
    c.valid          = 1'b1;
    c.command        = r.command;
    c.command_parity = odd_parity(64'(r.command), `CMD_CODE_BITS);
    c.address        = r.address;
    c.address_parity = odd_parity(r.address, `CMD_ADDR_BITS);
    c.tag            = tag;
    c.tag_parity     = odd_parity(64'(tag), `CMD_TAG_BITS);
    c.size           = r.size;
    c.abt            = command_issue_pkg::abt_strict;
    c.context_handle = 16'h0000;
    return c;
  endfunction

  // random address with the code picked round robin
  function automatic command_issue_pkg::cmd_request_t make_req(input int n);
    command_issue_pkg::cmd_request_t r;
    r.valid   = 1'b1;
    r.address = {$random(seed), $random(seed)};
    r.size    = 12'h040 + 12'(n * 16);
    case (n % 3)
      0:       r.command = command_issue_pkg::cmd_read_cl_na;
      1:       r.command = command_issue_pkg::cmd_write_na;
      default: r.command = command_issue_pkg::cmd_touch_i;
    endcase
    return r;
  endfunction

  task automatic check_cmd(input string name, input command_issue_pkg::cmd_out_t got,
                           input command_issue_pkg::cmd_out_t exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_tag(input string name, input logic [`CMD_TAG_BITS-1:0] got,
                           input logic [`CMD_TAG_BITS-1:0] exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic note_failure(input string msg);
    failure_count++;
    $display("error at %0t: %s", $time, msg);
  endtask

  // host side monitor comparing each command as it leaves
  task automatic take_command(input command_issue_pkg::cmd_out_t got);
    command_issue_pkg::cmd_request_t r;
    logic [`CMD_TAG_BITS-1:0] tag;
    if (exp_reqs.size() == 0 || free_tags.size() == 0) begin
      note_failure("command issued with no pending request or free tag");
    end else begin
      r = exp_reqs.pop_front();
      tag = free_tags.pop_front();
      check_cmd("command_out", got, expected_cmd(r, tag));
      // outstanding tags follow the model
      out_tags.push_back(tag);
    end
    seen_tags.push_back(got.tag);
    seen_count++;
  endtask

  always @(negedge clock) begin
    if (rstn && command_out.valid) begin
      take_command(command_out);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // drivers
  //////////////////////////////////////////////////////////////////////

  // every driver starts and ends just after a rising edge
  task automatic step(input int n);
    repeat (n) @(posedge clock);
    #0.5;
  endtask

  task automatic apply_reset();
    rstn = 1'b0;
    enabled_in = 1'b0;
    req = '0;
    resp = '0;
    exp_reqs.delete();
    out_tags.delete();
    seen_tags.delete();
    free_tags.delete();
    for (int i = 0; i < `CMD_NUM_TAGS; i++) begin
      free_tags.push_back(`CMD_TAG_BITS'(i));
    end
    seen_count = 0;
    step(4);
    rstn = 1'b1;
  endtask

  task automatic push_req(input command_issue_pkg::cmd_request_t r);
    if (req_full) begin
      note_failure("request queue full, request not sent");
    end else begin
      req = r;
      exp_reqs.push_back(r);
      step(1);
      req = '0;
    end
  endtask

  task automatic send_resp(input logic [`CMD_TAG_BITS-1:0] tag, input logic [7:0] credits,
                           input logic good);
    logic p;
    p = odd_parity(64'(tag), `CMD_TAG_BITS);
    resp.valid      = 1'b1;
    resp.tag        = tag;
    resp.tag_parity = good ? p : ~p;
    resp.code       = RESP_DONE;
    resp.credits    = credits;
    foreach (out_tags[i]) begin
      if (out_tags[i] == tag) begin
        out_tags.delete(i);
        break;
      end
    end
    // a tag with bad parity never comes back to the free list
    if (good) begin
      free_tags.push_back(tag);
    end
    step(1);
    resp = '0;
  endtask

  task automatic return_oldest(input logic [7:0] credits);
    if (out_tags.size() == 0) begin
      note_failure("no outstanding tag to return");
    end else begin
      send_resp(out_tags[0], credits, 1'b1);
    end
  endtask

  task automatic wait_for_cmds(input int n, input int limit);
    int cycles;
    cycles = 0;
    while (seen_count < n && cycles < limit) begin
      step(1);
      cycles++;
    end
    if (seen_count < n) begin
      note_failure($sformatf("timed out waiting for %0d commands, saw %0d", n, seen_count));
    end
  endtask

  task automatic wait_for_idle(input logic level, input int limit);
    int cycles;
    cycles = 0;
    while (idle !== level && cycles < limit) begin
      step(1);
      cycles++;
    end
    if (idle !== level) begin
      note_failure($sformatf("timed out waiting for idle to become %b", level));
    end
  endtask

  // no further command may show up inside the window
  task automatic expect_quiet(input int cycles, input int total);
    step(cycles);
    if (seen_count != total) begin
      note_failure($sformatf("expected %0d commands in total, saw %0d", total, seen_count));
    end
  endtask

  task automatic start_issue();
    enabled_in = 1'b1;
    wait_for_idle(1'b0, 10);
  endtask

  task automatic issue_batch(input int n);
    int target;
    target = seen_count + exp_reqs.size() + n;
    for (int i = 0; i < n; i++) begin
      push_req(make_req(i));
    end
    wait_for_cmds(target, 30);
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_state();
    apply_reset();
    check_bit("command_out.valid", command_out.valid, 1'b0);
    check_bit("parity_error", parity_error, 1'b0);
    check_bit("req_full", req_full, 1'b0);
    check_bit("idle", idle, 1'b1);
    start_issue();
    check_bit("idle", idle, 1'b0);
  endtask

  task automatic single_command();
    apply_reset();
    start_issue();
    issue_batch(1);
    if (seen_tags.size() > 0) begin
      check_tag("command_out.tag", seen_tags[0], 8'd0);
    end
  endtask

  // 4 credits stop the queue after four and 2 more release the rest
  task automatic credit_limit();
    apply_reset();
    start_issue();
    for (int i = 0; i < 6; i++) begin
      push_req(make_req(i));
    end
    wait_for_cmds(4, 20);
    expect_quiet(8, 4);
    return_oldest(8'd2);
    wait_for_cmds(6, 20);
    expect_quiet(4, 6);
  endtask

  task automatic tag_recycling();
    logic [`CMD_TAG_BITS-1:0] order[4];
    logic [`CMD_TAG_BITS-1:0] exp_tags[$];
    order = '{8'd2, 8'd0, 8'd3, 8'd1};
    apply_reset();
    start_issue();
    issue_batch(4);
    foreach (order[i]) begin
      send_resp(order[i], 8'd1, 1'b1);
    end
    for (int b = 0; b < 4; b++) begin
      issue_batch(4);
      repeat (4) return_oldest(8'd1);
    end
    // first lap in order and then the freed tags in response order
    for (int i = 0; i < `CMD_NUM_TAGS; i++) begin
      exp_tags.push_back(`CMD_TAG_BITS'(i));
    end
    foreach (order[i]) begin
      exp_tags.push_back(order[i]);
    end
    if (seen_tags.size() != exp_tags.size()) begin
      note_failure("wrong number of commands in the tag recycle test");
    end
    for (int i = 0; i < seen_tags.size() && i < exp_tags.size(); i++) begin
      check_tag("command_out.tag", seen_tags[i], exp_tags[i]);
    end
  endtask

  task automatic drain_on_disable();
    apply_reset();
    start_issue();
    issue_batch(2);
    enabled_in = 1'b0;
    step(3);
    push_req(make_req(0));
    push_req(make_req(1));
    expect_quiet(10, 2);
    check_bit("idle", idle, 1'b0);
    return_oldest(8'd1);
    step(3);
    // one tag still out so the drain goes on
    check_bit("idle", idle, 1'b0);
    return_oldest(8'd1);
    wait_for_idle(1'b1, 10);
    check_bit("idle", idle, 1'b1);
    enabled_in = 1'b1;
    wait_for_cmds(4, 20);
  endtask

  task automatic bad_tag_parity();
    apply_reset();
    start_issue();
    issue_batch(1);
    send_resp(8'd0, 8'd1, 1'b0);
    check_bit("parity_error", parity_error, 1'b1);
    // four issues need the credit that came with the bad response
    issue_batch(4);
    // one request beyond the credits stays queued
    push_req(make_req(4));
    expect_quiet(6, 5);
    repeat (4) return_oldest(8'd1);
    wait_for_cmds(6, 20);
    return_oldest(8'd1);
    for (int b = 0; b < 3; b++) begin
      issue_batch(4);
      repeat (4) return_oldest(8'd1);
    end
    for (int i = 1; i < seen_tags.size(); i++) begin
      if (seen_tags[i] == 8'd0) begin
        note_failure("tag 0 issued again after its parity error");
      end
    end
    check_bit("parity_error", parity_error, 1'b1);
  endtask

  initial begin
    seed = 53569;
    mismatch_count = 0;
    failure_count = 0;
    rstn = 1'b0;
    enabled_in = 1'b0;
    req = '0;
    resp = '0;
    reset_state();
    single_command();
    credit_limit();
    tag_recycling();
    drain_on_disable();
    bad_tag_parity();
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count + failure_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // hang guard
  initial begin
    #(WATCHDOG_NS);
    $display("error at %0t: watchdog expired before the tests finished", $time);
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* command_issue_top.f */
+incdir+.
command_issue_pkg.sv
request_queue.sv
tag_pool.sv
credit_counter.sv
issue_fsm.sv
command_control.sv
command_issue_top.sv
command_issue_asserts.sv
command_issue_tb.sv

/* Makefile */
SIM      ?= verilator
TOP      := command_issue_tb
FILELIST := command_issue_top.f
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
OBJ      := obj_dir
LOG      := sim.log
FAIL_MSG := Done: errors found

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ)

run: build
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi

lint:
	$(SIM) --lint-only --timing --timescale 1ns/1ps -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ) $(LOG)
